/* cpu_defines.svh */
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// RV32I base opcodes, bits [6:0] of the instruction word.
`define OPCODE_OP       7'b0110011
`define OPCODE_OP_IMM   7'b0010011
`define OPCODE_LUI      7'b0110111
`define OPCODE_AUIPC    7'b0010111
`define OPCODE_JAL      7'b1101111
`define OPCODE_JALR     7'b1100111
`define OPCODE_BRANCH   7'b1100011
`define OPCODE_LOAD     7'b0000011
`define OPCODE_STORE    7'b0100011

// funct3 codes for the OP and OP-IMM groups.
`define F3_ADD_SUB      3'b000
`define F3_SLL          3'b001
`define F3_SLT          3'b010
`define F3_SLTU         3'b011
`define F3_XOR          3'b100
`define F3_SRL_SRA      3'b101
`define F3_OR           3'b110
`define F3_AND          3'b111

// funct3 codes for the conditional branches.
`define F3_BEQ          3'b000
`define F3_BNE          3'b001
`define F3_BLT          3'b100
`define F3_BGE          3'b101
`define F3_BLTU         3'b110
`define F3_BGEU         3'b111

`define INITIAL_PC      32'h0000_0000
`define RAM_WORDS       1024
`define RAM_AW          10

`endif

/* cpu_pkg.sv */
package cpu_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_e;

    typedef struct packed {
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [31:0] imm;
        alu_op_e     alu_op;
        logic        use_imm;
        logic        use_pc;
        logic        reg_we;
        logic        is_load;
        logic        is_store;
        logic        is_branch;
        logic        is_jal;
        logic        is_jalr;
        logic [2:0]  funct3;
    } decoded_t;

    // Wishbone classic master request.
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [3:0]  sel;
        logic [31:0] adr;
        logic [31:0] dat;
    } wb_req_t;

    // One register write retired by the core.
    typedef struct packed {
        logic        valid;
        logic [4:0]  rd;
        logic [31:0] data;
        logic [31:0] pc;
    } commit_t;

endpackage

/* program_counter.sv */
`timescale 1ns/1ps

`include "cpu_defines.svh"

module program_counter (
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic        count_i,
    input  logic        load_i,
    input  logic [31:0] value_i,
    output logic [31:0] pc_o,
    output logic [31:0] pc_inc_o
);

    assign pc_inc_o = pc_o + 32'd4;

    // A jump or taken branch wins over the sequential step.
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pc_o <= `INITIAL_PC;
        end else if (load_i) begin
            pc_o <= value_i;
        end else if (count_i) begin
            pc_o <= pc_inc_o;
        end
    end

endmodule

/* registers.sv */
`timescale 1ns/1ps

module registers (
    input  logic        clk_i,
    input  logic        w_enable_i,
    input  logic [4:0]  w_address_i,
    input  logic [31:0] w_data_i,
    input  logic [4:0]  r_address1_i,
    input  logic [4:0]  r_address2_i,
    output logic [31:0] r_out1_o,
    output logic [31:0] r_out2_o
);

    logic [31:0] regs [32];

    always_ff @(posedge clk_i) begin
        if (w_enable_i && w_address_i != 5'd0) begin
            regs[w_address_i] <= w_data_i;
        end
    end

    // Entry 0 is never written, so x0 is forced to zero on the read side.
    always_ff @(posedge clk_i) begin
        r_out1_o <= (r_address1_i == 5'd0) ? 32'd0 : regs[r_address1_i];
        r_out2_o <= (r_address2_i == 5'd0) ? 32'd0 : regs[r_address2_i];
    end

endmodule

/* decoder.sv */
`timescale 1ns/1ps

`include "cpu_defines.svh"

module decoder import cpu_pkg::*; (
    input  logic [31:0] instruction_i,
    output decoded_t    decoded_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       alt;

    assign opcode = instruction_i[6:0];
    assign funct3 = instruction_i[14:12];
    assign alt    = instruction_i[30];

    // SUB only exists in the register form; SRA and SRAI both use bit 30.
    function automatic alu_op_e alu_from_funct(input logic [2:0] f3, input logic alt_bit,
                                               input logic is_reg);
        alu_op_e op;
        case (f3)
            `F3_ADD_SUB: op = (is_reg && alt_bit) ? ALU_SUB : ALU_ADD;
            `F3_SLL:     op = ALU_SLL;
            `F3_SLT:     op = ALU_SLT;
            `F3_SLTU:    op = ALU_SLTU;
            `F3_XOR:     op = ALU_XOR;
            `F3_SRL_SRA: op = alt_bit ? ALU_SRA : ALU_SRL;
            `F3_OR:      op = ALU_OR;
            default:     op = ALU_AND;
        endcase
        return op;
    endfunction

    always_comb begin
        decoded_o        = '0;
        decoded_o.rd     = instruction_i[11:7];
        decoded_o.rs1    = instruction_i[19:15];
        decoded_o.rs2    = instruction_i[24:20];
        decoded_o.funct3 = funct3;
        decoded_o.alu_op = ALU_ADD;
        // I-type immediate unless the opcode says otherwise.
        decoded_o.imm    = {{20{instruction_i[31]}}, instruction_i[31:20]};

        case (opcode)
            `OPCODE_OP: begin
                decoded_o.alu_op = alu_from_funct(funct3, alt, 1'b1);
                decoded_o.reg_we = 1'b1;
            end
            `OPCODE_OP_IMM: begin
                decoded_o.alu_op  = alu_from_funct(funct3, alt, 1'b0);
                decoded_o.use_imm = 1'b1;
                decoded_o.reg_we  = 1'b1;
            end
            `OPCODE_LUI, `OPCODE_AUIPC: begin
                decoded_o.imm     = {instruction_i[31:12], 12'd0};
                decoded_o.alu_op  = (opcode == `OPCODE_LUI) ? ALU_PASS_B : ALU_ADD;
                decoded_o.use_pc  = (opcode == `OPCODE_AUIPC);
                decoded_o.use_imm = 1'b1;
                decoded_o.reg_we  = 1'b1;
            end
            `OPCODE_JAL: begin
                decoded_o.imm     = {{11{instruction_i[31]}}, instruction_i[31],
                                     instruction_i[19:12], instruction_i[20],
                                     instruction_i[30:21], 1'b0};
                decoded_o.use_pc  = 1'b1;
                decoded_o.use_imm = 1'b1;
                decoded_o.reg_we  = 1'b1;
                decoded_o.is_jal  = 1'b1;
            end
            `OPCODE_JALR: begin
                decoded_o.use_imm = 1'b1;
                decoded_o.reg_we  = 1'b1;
                decoded_o.is_jalr = 1'b1;
            end
            `OPCODE_BRANCH: begin
                decoded_o.imm       = {{19{instruction_i[31]}}, instruction_i[31],
                                       instruction_i[7], instruction_i[30:25],
                                       instruction_i[11:8], 1'b0};
                decoded_o.use_pc    = 1'b1;
                decoded_o.use_imm   = 1'b1;
                decoded_o.is_branch = 1'b1;
            end
            `OPCODE_LOAD: begin
                decoded_o.use_imm = 1'b1;
                decoded_o.reg_we  = 1'b1;
                decoded_o.is_load = 1'b1;
            end
            `OPCODE_STORE: begin
                decoded_o.imm      = {{20{instruction_i[31]}}, instruction_i[31:25],
                                      instruction_i[11:7]};
                decoded_o.use_imm  = 1'b1;
                decoded_o.is_store = 1'b1;
            end
            default: begin
                decoded_o.reg_we = 1'b0;
            end
        endcase
    end

endmodule

/* alu.sv */
`timescale 1ns/1ps

module alu import cpu_pkg::*; (
    input  alu_op_e     op_i,
    input  logic [31:0] op_a_i,
    input  logic [31:0] op_b_i,
    output logic [31:0] out_o
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = op_b_i[4:0];
    assign lt_signed   = $signed(op_a_i) < $signed(op_b_i);
    assign lt_unsigned = op_a_i < op_b_i;

    always_comb begin
        case (op_i)
            ALU_ADD:    out_o = op_a_i + op_b_i;
            ALU_SUB:    out_o = op_a_i - op_b_i;
            ALU_SLL:    out_o = op_a_i << shamt;
            ALU_SLT:    out_o = {31'd0, lt_signed};
            ALU_SLTU:   out_o = {31'd0, lt_unsigned};
            ALU_XOR:    out_o = op_a_i ^ op_b_i;
            ALU_SRL:    out_o = op_a_i >> shamt;
            ALU_SRA:    out_o = $unsigned($signed(op_a_i) >>> shamt);
            ALU_OR:     out_o = op_a_i | op_b_i;
            ALU_AND:    out_o = op_a_i & op_b_i;
            ALU_PASS_B: out_o = op_b_i;
            default:    out_o = 32'd0;
        endcase
    end

endmodule

/* cpu.sv */
`timescale 1ns/1ps

`include "cpu_defines.svh"

module cpu import cpu_pkg::*; #(
    parameter logic [31:0] INITIAL_PC = `INITIAL_PC
) (
    input  logic        clk_i,
    input  logic        rst_i,
    output wb_req_t     bus_o,
    input  logic [31:0] bus_dat_i,
    input  logic        bus_ack_i,
    output commit_t     commit_o
);

    typedef enum logic [2:0] {
        S_FETCH, S_REG_READ, S_EXECUTE, S_MEMORY, S_REG_WRITE, S_RESET
    } state_e;

    state_e      state;
    logic [31:0] instr_r;
    decoded_t    dec;
    decoded_t    dec_r;
    logic        pc_count;
    logic        pc_load;
    logic [31:0] pc_value;
    logic [31:0] pc;
    logic [31:0] pc_inc;
    logic        w_enable;
    logic [31:0] wb_data;
    logic [31:0] r_out1;
    logic [31:0] r_out2;
    logic [31:0] alu_a;
    logic [31:0] alu_b;
    logic [31:0] alu_out;
    logic [31:0] alu_out_r;
    logic        branch_cond;
    logic        taken_r;
    logic [31:0] load_data_r;
    logic        mem_access;

    program_counter program_counter (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .count_i  (pc_count),
        .load_i   (pc_load),
        .value_i  (pc_value),
        .pc_o     (pc),
        .pc_inc_o (pc_inc)
    );

    registers registers (
        .clk_i        (clk_i),
        .w_enable_i   (w_enable),
        .w_address_i  (dec_r.rd),
        .w_data_i     (wb_data),
        .r_address1_i (dec.rs1),
        .r_address2_i (dec.rs2),
        .r_out1_o     (r_out1),
        .r_out2_o     (r_out2)
    );

    decoder decoder (
        .instruction_i (instr_r),
        .decoded_o     (dec)
    );

    // Jump and branch targets also come out of the ALU, as pc or rs1 plus imm.
    assign alu_a = dec_r.use_pc ? pc : r_out1;
    assign alu_b = dec_r.use_imm ? dec_r.imm : r_out2;

    alu alu (
        .op_i   (dec_r.alu_op),
        .op_a_i (alu_a),
        .op_b_i (alu_b),
        .out_o  (alu_out)
    );

    always_comb begin
        case (dec_r.funct3)
            `F3_BEQ:  branch_cond = (r_out1 == r_out2);
            `F3_BNE:  branch_cond = (r_out1 != r_out2);
            `F3_BLT:  branch_cond = ($signed(r_out1) < $signed(r_out2));
            `F3_BGE:  branch_cond = ($signed(r_out1) >= $signed(r_out2));
            `F3_BLTU: branch_cond = (r_out1 < r_out2);
            `F3_BGEU: branch_cond = (r_out1 >= r_out2);
            default:  branch_cond = 1'b0;
        endcase
    end

    assign mem_access = dec_r.is_load | dec_r.is_store;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state <= S_RESET;
        end else begin
            case (state)
                S_FETCH:     if (bus_ack_i) state <= S_REG_READ;
                S_REG_READ:  state <= S_EXECUTE;
                S_EXECUTE:   state <= S_MEMORY;
                S_MEMORY:    if (!mem_access || bus_ack_i) state <= S_REG_WRITE;
                S_REG_WRITE: state <= S_FETCH;
                default:     state <= S_FETCH;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state == S_FETCH && bus_ack_i) begin
            instr_r <= bus_dat_i;
        end
        if (state == S_REG_READ) begin
            dec_r <= dec;
        end
        if (state == S_EXECUTE) begin
            alu_out_r <= alu_out;
            taken_r   <= branch_cond;
        end
        if (state == S_MEMORY && bus_ack_i) begin
            load_data_r <= bus_dat_i;
        end
    end

    always_comb begin
        if (dec_r.is_jal || dec_r.is_jalr) begin
            wb_data = pc_inc;
        end else if (dec_r.is_load) begin
            wb_data = load_data_r;
        end else begin
            wb_data = alu_out_r;
        end
    end

    always_comb begin
        bus_o    = '0;
        pc_count = 1'b0;
        pc_load  = 1'b0;
        pc_value = {alu_out_r[31:1], 1'b0};
        w_enable = 1'b0;

        case (state)
            S_RESET: begin
                pc_load  = 1'b1;
                pc_value = INITIAL_PC;
            end
            S_FETCH: begin
                bus_o.cyc = 1'b1;
                bus_o.stb = 1'b1;
                bus_o.sel = 4'b1111;
                bus_o.adr = pc;
            end
            S_MEMORY: begin
                bus_o.cyc = mem_access;
                bus_o.stb = mem_access;
                bus_o.we  = dec_r.is_store;
                bus_o.sel = 4'b1111;
                bus_o.adr = alu_out_r;
                bus_o.dat = r_out2;
            end
            S_REG_WRITE: begin
                w_enable = dec_r.reg_we;
                pc_load  = dec_r.is_jal | dec_r.is_jalr | (dec_r.is_branch & taken_r);
                pc_count = ~pc_load;
            end
            default: begin
                w_enable = 1'b0;
            end
        endcase
    end

    // The PC still points at the retiring instruction during REG_WRITE.
    assign commit_o.valid = w_enable && (dec_r.rd != 5'd0);
    assign commit_o.rd    = dec_r.rd;
    assign commit_o.data  = wb_data;
    assign commit_o.pc    = pc;

endmodule

/* wb_ram.sv */
`timescale 1ns/1ps

`include "cpu_defines.svh"

module wb_ram import cpu_pkg::*; (
    input  logic               clk_i,
    input  logic               rst_i,
    input  wb_req_t            req_i,
    output logic [31:0]        dat_o,
    output logic               ack_o,
    input  logic               load_we_i,
    input  logic [`RAM_AW-1:0] load_adr_i,
    input  logic [31:0]        load_dat_i
);

    logic [31:0]        mem [`RAM_WORDS];
    logic [`RAM_AW-1:0] word_adr;
    logic               access;

    // Byte address to word index; only full-word transfers are supported.
    assign word_adr = req_i.adr[`RAM_AW+1:2];
    assign access   = req_i.cyc & req_i.stb & ~ack_o;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ack_o <= 1'b0;
        end else begin
            ack_o <= access;
        end
    end

    always_ff @(posedge clk_i) begin
        if (load_we_i) begin
            mem[load_adr_i] <= load_dat_i;
        end else if (access && req_i.we) begin
            mem[word_adr] <= req_i.dat;
        end
        if (access) begin
            dat_o <= mem[word_adr];
        end
    end

endmodule

/* cpu_system.sv */
`timescale 1ns/1ps

`include "cpu_defines.svh"

module cpu_system import cpu_pkg::*; (
    input  logic               clk_i,
    input  logic               rst_i,
    input  logic               load_we_i,
    input  logic [`RAM_AW-1:0] load_adr_i,
    input  logic [31:0]        load_dat_i,
    output commit_t            commit_o
);

    wb_req_t     bus_req;
    logic [31:0] ram_dat;
    logic        ram_ack;

    cpu #(
        .INITIAL_PC (`INITIAL_PC)
    ) core (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .bus_o     (bus_req),
        .bus_dat_i (ram_dat),
        .bus_ack_i (ram_ack),
        .commit_o  (commit_o)
    );

    wb_ram ram (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .req_i      (bus_req),
        .dat_o      (ram_dat),
        .ack_o      (ram_ack),
        .load_we_i  (load_we_i),
        .load_adr_i (load_adr_i),
        .load_dat_i (load_dat_i)
    );

endmodule

/* tb_checker.sv */
`timescale 1ns/1ps

module tb_checker import cpu_pkg::*; (
    input  logic    clk_i,
    input  logic    rst_i,
    input  commit_t commit_i,
    output logic    done_o,
    output int      seen_o,
    output int      passed_o,
    output int      failed_o,
    output int      extra_o
);

    typedef struct packed {
        int          test;
        logic [4:0]  rd;
        logic [31:0] data;
        logic [31:0] pc;
    } exp_entry_t;

    exp_entry_t exp_q[$];
    string      test_names[$];
    int         next_idx = 0;
    int         test_errors = 0;
    int         test_writes = 0;
    int         passed = 0;
    int         failed = 0;
    int         extra = 0;
    logic       done = 1'b0;

    assign done_o   = done;
    assign seen_o   = next_idx;
    assign passed_o = passed;
    assign failed_o = failed;
    assign extra_o  = extra;

    task automatic add_test(input string name);
        test_names.push_back(name);
    endtask

    task automatic add_expected(input logic [4:0] rd, input logic [31:0] data,
                                input logic [31:0] pc);
        exp_entry_t e;
        if (test_names.size() == 0) begin
            test_names.push_back("unnamed");
        end
        e.test = test_names.size() - 1;
        e.rd   = rd;
        e.data = data;
        e.pc   = pc;
        exp_q.push_back(e);
    endtask

    task automatic compare_field(input string field, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (actual !== expected) begin
            $display("FAILED at %0d ns: write %0d, %s expected %h, got %h",
                     $time, next_idx, field, expected, actual);
            test_errors++;
        end
    endtask

    task automatic close_test(input int test);
        if (test_errors == 0) begin
            passed++;
            $display("Test %s passed, %0d writes checked", test_names[test], test_writes);
        end else begin
            failed++;
            $display("Test %s failed with %0d mismatches", test_names[test], test_errors);
        end
        test_errors = 0;
        test_writes = 0;
    endtask

    // Commits must arrive in exactly the order of the expected list.
    task automatic check_commit(input commit_t c);
        exp_entry_t e;
        if (next_idx >= exp_q.size()) begin
            extra++;
            $display("Unexpected write of %h to x%0d from pc %h after the last expected write",
                     c.data, c.rd, c.pc);
        end else begin
            e = exp_q[next_idx];
            compare_field("rd", {27'd0, e.rd}, {27'd0, c.rd});
            compare_field("data", e.data, c.data);
            compare_field("pc", e.pc, c.pc);
            test_writes++;
            next_idx++;
            if (next_idx == exp_q.size()) begin
                close_test(e.test);
                done = 1'b1;
            end else if (exp_q[next_idx].test != e.test) begin
                close_test(e.test);
            end
        end
    endtask

    always @(posedge clk_i) begin
        if (!rst_i && commit_i.valid) begin
            check_commit(commit_i);
        end
    end

endmodule

/* tb_cpu.sv */
`timescale 1ns/1ps

`include "cpu_defines.svh"

module tb_cpu import cpu_pkg::*; ();

    logic               clk;
    logic               rst;
    logic               load_we;
    logic [`RAM_AW-1:0] load_adr;
    logic [31:0]        load_dat;
    commit_t            commit;
    logic               chk_done;
    int                 chk_seen;
    int                 tests_passed;
    int                 tests_failed;
    int                 extra_writes;

    logic [31:0] prog_adr[$];
    logic [31:0] prog_word[$];
    int          n_expected = 0;
    int          stim_errors = 0;

    cpu_system DUT (
        .clk_i      (clk),
        .rst_i      (rst),
        .load_we_i  (load_we),
        .load_adr_i (load_adr),
        .load_dat_i (load_dat),
        .commit_o   (commit)
    );

    tb_checker commit_chk (
        .clk_i    (clk),
        .rst_i    (rst),
        .commit_i (commit),
        .done_o   (chk_done),
        .seen_o   (chk_seen),
        .passed_o (tests_passed),
        .failed_o (tests_failed),
        .extra_o  (extra_writes)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // A '#' anywhere starts a comment that runs to the end of the line.
    task automatic read_stim(input int fd);
        int              c;
        int              n;
        logic [7:0]      kind;
        logic [31:0]     a;
        logic [31:0]     b;
        logic [31:0]     p;
        logic [8*32-1:0] name;
        c = $fgetc(fd);
        while (c != -1) begin
            kind = c[7:0];
            if (kind == "#") begin
                while (c != -1 && c[7:0] != "\n") begin
                    c = $fgetc(fd);
                end
            end else if (kind == "P") begin
                n = $fscanf(fd, "%h %h", a, b);
                if (n != 2) begin
                    stim_errors++;
                    $display("Malformed program line in cpu_stim.txt");
                end
                prog_adr.push_back(a);
                prog_word.push_back(b);
            end else if (kind == "T") begin
                n = $fscanf(fd, "%s", name);
                if (n != 1) begin
                    stim_errors++;
                    $display("Malformed test line in cpu_stim.txt");
                end
                commit_chk.add_test(string'(name));
            end else if (kind == "E") begin
                n = $fscanf(fd, "%d %h %h", a, b, p);
                if (n != 3) begin
                    stim_errors++;
                    $display("Malformed expected-write line in cpu_stim.txt");
                end
                commit_chk.add_expected(a[4:0], b, p);
                n_expected++;
            end
            c = $fgetc(fd);
        end
    endtask

    task automatic load_program();
        foreach (prog_adr[i]) begin
            @(posedge clk);
            #1;
            load_we  = 1'b1;
            load_adr = prog_adr[i][`RAM_AW+1:2];
            load_dat = prog_word[i];
        end
        @(posedge clk);
        #1;
        load_we = 1'b0;
    endtask

    initial begin
        int fd;
        int cycles;
        int limit;
        rst      = 1'b1;
        load_we  = 1'b0;
        load_adr = '0;
        load_dat = '0;
        fd = $fopen("cpu_stim.txt", "r");
        if (fd == 0) begin
            $display("Could not open cpu_stim.txt");
            $display("Something failed");
            $finish;
        end else begin
            read_stim(fd);
            $fclose(fd);
            limit = 10 * n_expected + 200;
            // The program goes in while the core is still held in reset.
            load_program();
            repeat (8) @(posedge clk);
            #1;
            rst = 1'b0;
            cycles = 0;
            while (!chk_done && cycles < limit) begin
                @(posedge clk);
                cycles++;
            end
            if (!chk_done) begin
                $display("Timeout after %0d cycles, the program stopped committing", cycles);
                $display("%0d of %0d expected writes were seen", chk_seen, n_expected);
                $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
                $display("Something failed");
                $finish;
            end else begin
                // The final self-loop must stay silent.
                repeat (20) @(posedge clk);
                $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
                if (tests_failed == 0 && extra_writes == 0 && stim_errors == 0) begin
                    $display("Everything OK");
                end else begin
                    $display("Something failed");
                end
                $finish;
            end
        end
    end

endmodule

/* cpu_stim.txt */
# P <byte address> <word> loads one program word, T <name> starts a test,
# E <rd> <value> <pc> is the next expected register write, in commit order.
T imm_ops
P 00 00500093 # addi x1, x0, 5
P 04 ffd00113 # addi x2, x0, -3
P 08 00112193 # slti x3, x2, 1
P 0c 0f00c213 # xori x4, x1, 0xf0
P 10 00409293 # slli x5, x1, 4
P 14 40115313 # srai x6, x2, 1
P 18 123453b7 # lui x7, 0x12345
P 1c 00001417 # auipc x8, 1
E 1 00000005 00000000
E 2 fffffffd 00000004
E 3 00000001 00000008
E 4 000000f5 0000000c
E 5 00000050 00000010
E 6 fffffffe 00000014
E 7 12345000 00000018
E 8 0000101c 0000001c
T reg_ops
P 20 002084b3 # add x9, x1, x2
P 24 40208533 # sub x10, x1, x2
P 28 001125b3 # slt x11, x2, x1
P 2c 00113633 # sltu x12, x2, x1
P 30 004176b3 # and x13, x2, x4
P 34 0050e733 # or x14, x1, x5
P 38 401157b3 # sra x15, x2, x1
P 3c 00115833 # srl x16, x2, x1
P 40 00108033 # add x0, x1, x1 (no commit)
E 9 00000002 00000020
E 10 00000008 00000024
E 11 00000001 00000028
E 12 00000000 0000002c
E 13 000000f5 00000030
E 14 00000055 00000034
E 15 ffffffff 00000038
E 16 07ffffff 0000003c
T store_load
P 44 20000893 # addi x17, x0, 0x200
P 48 0078a223 # sw x7, 4(x17)
P 4c 0028a023 # sw x2, 0(x17)
P 50 0048a903 # lw x18, 4(x17)
P 54 0008a983 # lw x19, 0(x17)
E 17 00000200 00000044
E 18 12345000 00000050
E 19 fffffffd 00000054
T branches
P 58 00108463 # beq x1, x1, +8 (taken)
P 5c 00100a13 # addi x20, x0, 1
P 60 00109463 # bne x1, x1, +8 (not taken)
P 64 00200a13 # addi x20, x0, 2
P 68 00114463 # blt x2, x1, +8 (taken)
P 6c 00300a13 # addi x20, x0, 3
P 70 00115463 # bge x2, x1, +8 (not taken)
P 74 00400a13 # addi x20, x0, 4
P 78 00116463 # bltu x2, x1, +8 (not taken)
P 7c 00500a13 # addi x20, x0, 5
P 80 00117463 # bgeu x2, x1, +8 (taken)
P 84 00600a13 # addi x20, x0, 6
E 20 00000002 00000064
E 20 00000004 00000074
E 20 00000005 0000007c
T jumps
P 88 00800aef # jal x21, +8
P 8c 00700b13 # addi x22, x0, 7
P 90 09d00b93 # addi x23, x0, 0x9d
P 94 000b8c67 # jalr x24, 0(x23)
P 98 00900b13 # addi x22, x0, 9
P 9c 00100c93 # addi x25, x0, 1
P a0 0000006f # jal x0, 0
E 21 0000008c 00000088
E 23 0000009d 00000090
E 24 00000098 00000094
E 25 00000001 0000009c

/* verilog.f */
+incdir+.
cpu_pkg.sv
program_counter.sv
registers.sv
decoder.sv
alu.sv
cpu.sv
wb_ram.sv
cpu_system.sv
tb_checker.sv
tb_cpu.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it from the project root.

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "Cannot change to the project directory"
    exit 1
fi

verilator --binary --timing --timescale 1ns/1ps -f verilog.f --top-module tb_cpu \
    -Mdir obj_dir -o tb_cpu_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_cpu_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Something failed" sim.log; then
    exit 1
fi
exit 0
